// File: Makefile
# Verilator flow for the memory issue queue

VERILATOR  ?= verilator
TOP        ?= tb_mem_issue_queue
DUT_TOP    ?= mem_issue_queue
FILELIST   ?= mem_issue_queue.f
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/100ps
JOBS       ?= 0
VFLAGS     ?= --binary --timing -j $(JOBS) --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only -Wall --timescale $(TIMESCALE)
PASS_MSG   ?= Test passed

# Sources in compile order, taken from the file list
SRCS     := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
RTL_SRCS := $(filter design/%,$(SRCS))
SIM      := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) tb/tb_mem_iq_tasks.svh $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

// File: design/mem_iq_alloc.sv
`timescale 1ns/100ps
`default_nettype none

module mem_iq_alloc #(
    parameter int IQ_DEPTH = 8,
    localparam int IDX_W = $clog2(IQ_DEPTH)
) (
    input  wire logic [IQ_DEPTH-1:0] slot_valid,
    input  wire logic [1:0]          disp_valid,
    output logic      [1:0]          disp_ready,
    output logic      [1:0][IDX_W-1:0] alloc_idx,
    output logic      [1:0]          disp_fire
);

    // ========================================================================
    // Free slot scan
    // ========================================================================

    logic [IQ_DEPTH-1:0] free_vec;
    logic                found0;
    logic                found1;

    assign free_vec = ~slot_valid;

    // Lowest free slot goes to lane 0, the next one up to lane 1
    always_comb begin
        found0 = 1'b0;
        found1 = 1'b0;
        alloc_idx[0] = '0;
        alloc_idx[1] = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (free_vec[i]) begin
                if (!found0) begin
                    alloc_idx[0] = IDX_W'(i);
                    found0 = 1'b1;
                end else if (!found1) begin
                    alloc_idx[1] = IDX_W'(i);
                    found1 = 1'b1;
                end
            end
        end
    end

    // ========================================================================
    // Lane handshake
    // ========================================================================

    // Lane 0 needs one free slot, lane 1 needs two
    assign disp_ready[0] = found0;
    assign disp_ready[1] = found1;

    // Accepted at the next edge
    assign disp_fire = disp_valid & disp_ready;

endmodule

`default_nettype wire

// File: design/mem_iq_issue_reg.sv
`timescale 1ns/100ps
`default_nettype none

module mem_iq_issue_reg
    import mem_iq_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     issue_stall,
    input  wire logic     sel_valid,
    input  wire mem_uop_t sel_uop,
    output logic          issue_valid,
    output mem_uop_t      issue_uop
);

    // ========================================================================
    // Pipeline register towards the memory pipe
    // ========================================================================

    // Valid bit, frozen while the memory pipe stalls
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else if (!issue_stall) begin
            issue_valid <= sel_valid;
        end
    end

    // Payload only moves with a real selection
    always_ff @(posedge clk) begin
        if (!issue_stall && sel_valid) begin
            issue_uop <= sel_uop;
        end
    end

endmodule

`default_nettype wire

// File: design/mem_iq_pkg.sv
`default_nettype none

package mem_iq_pkg;

    // ========================================================================
    // Widths
    // ========================================================================

    // Physical register specifier
    localparam int PRF_W = 6;
    // ROB tag
    localparam int ROB_W = 5;
    // Result broadcasts per cycle from the execution units
    localparam int WAKE_PORTS = 2;

    typedef logic [PRF_W-1:0] prf_t;
    typedef logic [ROB_W-1:0] rob_tag_t;

    // ========================================================================
    // Micro-op and broadcast types
    // ========================================================================

    // Memory opcode, a single bit
    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_op_t;

    // Micro-op as it reaches the memory pipe, 24 bits
    typedef struct packed {
        mem_op_t  op;
        prf_t     rd;
        prf_t     rs1;
        prf_t     rs2;
        rob_tag_t rob_tag;
    } mem_uop_t;

    // Dispatch lane payload with operand readiness as rename knows it
    typedef struct packed {
        mem_uop_t uop;
        logic     rs1_ready;
        logic     rs2_ready;
    } mem_dispatch_t;

    // One result-tag broadcast
    typedef struct packed {
        logic valid;
        prf_t tag;
    } wake_t;

endpackage

`default_nettype wire

// File: design/mem_iq_select.sv
`timescale 1ns/100ps
`default_nettype none

module mem_iq_select #(
    parameter int IQ_DEPTH = 8,
    localparam int IDX_W = $clog2(IQ_DEPTH)
) (
    input  wire logic [IQ_DEPTH-1:0] issuable,
    input  wire logic [IQ_DEPTH-1:0] is_store,
    output logic                     sel_valid,
    output logic      [IDX_W-1:0]    sel_idx
);

    logic [IQ_DEPTH-1:0] load_req;
    logic [IQ_DEPTH-1:0] store_req;

    // Lowest set bit of a request vector
    function automatic logic [IDX_W-1:0] lowest(input logic [IQ_DEPTH-1:0] req);
        logic [IDX_W-1:0] idx;
        idx = '0;
        // Scan downward so the lowest hit is written last
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (req[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    // ========================================================================
    // Load-over-store pick
    // ========================================================================

    assign load_req  = issuable & ~is_store;
    assign store_req = issuable & is_store;

    always_comb begin
        sel_valid = |issuable;
        // Loads first, stores only when no load is ready
        if (|load_req) begin
            sel_idx = lowest(load_req);
        end else begin
            sel_idx = lowest(store_req);
        end
    end

endmodule

`default_nettype wire

// File: design/mem_iq_slot_array.sv
`timescale 1ns/100ps
`default_nettype none

module mem_iq_slot_array
    import mem_iq_pkg::*;
#(
    parameter int IQ_DEPTH = 8,
    localparam int IDX_W = $clog2(IQ_DEPTH)
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire mem_dispatch_t [1:0]       disp_pack,
    input  wire logic [1:0]                disp_fire,
    input  wire logic [1:0][IDX_W-1:0]     alloc_idx,
    input  wire wake_t [WAKE_PORTS-1:0]    wake,
    input  wire logic                      sel_valid,
    input  wire logic [IDX_W-1:0]          sel_idx,
    input  wire logic                      issue_stall,
    output logic      [IQ_DEPTH-1:0]       slot_valid,
    output logic      [IQ_DEPTH-1:0]       issuable,
    output logic      [IQ_DEPTH-1:0]       is_store,
    output mem_uop_t                       sel_uop
);

    // Entry payload, no reset
    mem_uop_t            slot_uop [IQ_DEPTH];
    // Operand ready bits per entry
    logic [IQ_DEPTH-1:0] rs1_rdy;
    logic [IQ_DEPTH-1:0] rs2_rdy;
    // Bit j set means entry j is older and must issue first
    logic [IQ_DEPTH-1:0] dep_vec [IQ_DEPTH];

    logic [IQ_DEPTH-1:0]      leave_vec;
    logic [1:0][IQ_DEPTH-1:0] lane_hit;
    logic [1:0][IQ_DEPTH-1:0] lane_dep;
    logic [1:0]               lane_rs1_rdy;
    logic [1:0]               lane_rs2_rdy;
    logic [IQ_DEPTH-1:0]      older_valid;
    logic [IQ_DEPTH-1:0]      older_store;

    // Any valid broadcast carrying this register
    function automatic logic wake_hit(input prf_t src, input wake_t [WAKE_PORTS-1:0] bus);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < WAKE_PORTS; p++) begin
            if (bus[p].valid && bus[p].tag == src) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // ========================================================================
    // Per-entry status
    // ========================================================================

    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            // Selected entry leaves only when the memory pipe takes it
            leave_vec[i] = sel_valid && !issue_stall && (sel_idx == IDX_W'(i));
            is_store[i]  = (slot_uop[i].op == MEM_STORE);
            issuable[i]  = slot_valid[i] && rs1_rdy[i] && rs2_rdy[i] && (dep_vec[i] == '0);
            for (int k = 0; k < 2; k++) begin
                lane_hit[k][i] = disp_fire[k] && (alloc_idx[k] == IDX_W'(i));
            end
        end
    end

    // ========================================================================
    // Dispatch side, bypass and ordering
    // ========================================================================

    // Entries leaving at this edge are no longer older
    assign older_valid = slot_valid & ~leave_vec;
    assign older_store = older_valid & is_store;

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            lane_rs1_rdy[k] = disp_pack[k].rs1_ready || wake_hit(disp_pack[k].uop.rs1, wake);
            lane_rs2_rdy[k] = disp_pack[k].rs2_ready || wake_hit(disp_pack[k].uop.rs2, wake);
        end
        // Store waits on all older entries, load only on older stores
        lane_dep[0] = (disp_pack[0].uop.op == MEM_STORE) ? older_valid : older_store;
        // Lane 0 is older than lane 1
        if (disp_pack[1].uop.op == MEM_STORE) begin
            lane_dep[1] = older_valid | lane_hit[0];
        end else if (disp_pack[0].uop.op == MEM_STORE) begin
            lane_dep[1] = older_store | lane_hit[0];
        end else begin
            lane_dep[1] = older_store;
        end
    end

    // ========================================================================
    // Entry state
    // ========================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= '0;
            rs1_rdy    <= '0;
            rs2_rdy    <= '0;
            for (int i = 0; i < IQ_DEPTH; i++) begin
                dep_vec[i] <= '0;
            end
        end else begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (lane_hit[0][i] || lane_hit[1][i]) begin
                    slot_valid[i] <= 1'b1;
                    rs1_rdy[i]    <= lane_hit[0][i] ? lane_rs1_rdy[0] : lane_rs1_rdy[1];
                    rs2_rdy[i]    <= lane_hit[0][i] ? lane_rs2_rdy[0] : lane_rs2_rdy[1];
                    dep_vec[i]    <= lane_hit[0][i] ? lane_dep[0] : lane_dep[1];
                end else begin
                    if (leave_vec[i]) begin
                        slot_valid[i] <= 1'b0;
                    end
                    // Wakeup from the result broadcast
                    if (wake_hit(slot_uop[i].rs1, wake)) begin
                        rs1_rdy[i] <= 1'b1;
                    end
                    if (wake_hit(slot_uop[i].rs2, wake)) begin
                        rs2_rdy[i] <= 1'b1;
                    end
                    // Release dependents of the issuing entry
                    dep_vec[i] <= dep_vec[i] & ~leave_vec;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (lane_hit[0][i]) begin
                slot_uop[i] <= disp_pack[0].uop;
            end else if (lane_hit[1][i]) begin
                slot_uop[i] <= disp_pack[1].uop;
            end
        end
    end

    // Chosen entry towards the issue register
    assign sel_uop = slot_uop[sel_idx];

endmodule

`default_nettype wire

// File: design/mem_issue_queue.sv
`timescale 1ns/100ps
`default_nettype none

module mem_issue_queue
    import mem_iq_pkg::*;
#(
    parameter int IQ_DEPTH = 8,
    localparam int IDX_W = $clog2(IQ_DEPTH)
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    // Dispatch from rename, lane 0 is older
    input  wire logic [1:0]             disp_valid,
    input  wire mem_dispatch_t [1:0]    disp_pack,
    output logic      [1:0]             disp_ready,
    // Result broadcasts
    input  wire wake_t [WAKE_PORTS-1:0] wake,
    // Issue to the memory pipe
    input  wire logic                   issue_stall,
    output logic                        issue_valid,
    output mem_uop_t                    issue_uop
);

    logic [IQ_DEPTH-1:0]   slot_valid;
    logic [IQ_DEPTH-1:0]   issuable;
    logic [IQ_DEPTH-1:0]   is_store;
    logic [1:0][IDX_W-1:0] alloc_idx;
    logic [1:0]            disp_fire;
    logic                  sel_valid;
    logic [IDX_W-1:0]      sel_idx;
    mem_uop_t              sel_uop;

    // ========================================================================
    // Allocation, storage, select and issue register
    // ========================================================================

    mem_iq_alloc #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_alloc (
        .slot_valid (slot_valid),
        .disp_valid (disp_valid),
        .disp_ready (disp_ready),
        .alloc_idx  (alloc_idx),
        .disp_fire  (disp_fire)
    );

    mem_iq_slot_array #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_slot_array (
        .clk         (clk),
        .rst         (rst),
        .disp_pack   (disp_pack),
        .disp_fire   (disp_fire),
        .alloc_idx   (alloc_idx),
        .wake        (wake),
        .sel_valid   (sel_valid),
        .sel_idx     (sel_idx),
        .issue_stall (issue_stall),
        .slot_valid  (slot_valid),
        .issuable    (issuable),
        .is_store    (is_store),
        .sel_uop     (sel_uop)
    );

    mem_iq_select #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_select (
        .issuable  (issuable),
        .is_store  (is_store),
        .sel_valid (sel_valid),
        .sel_idx   (sel_idx)
    );

    mem_iq_issue_reg u_issue_reg (
        .clk         (clk),
        .rst         (rst),
        .issue_stall (issue_stall),
        .sel_valid   (sel_valid),
        .sel_uop     (sel_uop),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop)
    );

endmodule

`default_nettype wire

// File: mem_issue_queue.f
+incdir+tb
design/mem_iq_pkg.sv
design/mem_iq_alloc.sv
design/mem_iq_slot_array.sv
design/mem_iq_select.sv
design/mem_iq_issue_reg.sv
design/mem_issue_queue.sv
tb/tb_mem_issue_queue.sv

// File: tb/tb_mem_iq_tasks.svh
`ifndef TB_MEM_IQ_TASKS_SVH
`define TB_MEM_IQ_TASKS_SVH

// Empty queue, nothing at the issue port
task automatic check_reset_state();
    check_bit("issue_valid", 1'b0, issue_valid);
    check_ready("disp_ready", 2'b11, disp_ready);
endtask

// Fully ready load, two edges from dispatch to the port
task automatic ready_load_issue();
    mem_uop_t u;
    u = rand_uop(MEM_LOAD);
    issued_q.delete();
    dispatch(2'b01, dpack(u, 1'b1, 1'b1), '0);
    expect_issue(u);
    expect_quiet(2);
endtask

task automatic wakeup_and_bypass();
    mem_uop_t u;
    u     = rand_uop(MEM_LOAD);
    u.rs1 = 6'd17;
    issued_q.delete();
    dispatch(2'b01, dpack(u, 1'b0, 1'b1), '0);
    // Waits on rs1 as long as no tag shows up
    expect_quiet(6);
    wake[0] = '{valid: 1'b1, tag: 6'd17};
    tick();
    wake = '0;
    expect_issue(u);
    // Broadcast in the dispatch cycle itself
    u       = rand_uop(MEM_LOAD);
    u.rs1   = 6'd23;
    wake[1] = '{valid: 1'b1, tag: 6'd23};
    dispatch(2'b01, dpack(u, 1'b0, 1'b1), '0);
    expect_issue(u);
    expect_quiet(2);
endtask

task automatic load_store_order();
    mem_uop_t st;
    mem_uop_t ld0;
    mem_uop_t ld1;
    st     = rand_uop(MEM_STORE);
    st.rs2 = 6'd30;
    ld0    = rand_uop(MEM_LOAD);
    ld1    = rand_uop(MEM_LOAD);
    issued_q.delete();
    dispatch(2'b01, dpack(st, 1'b1, 1'b0), '0);
    dispatch(2'b11, dpack(ld0, 1'b1, 1'b1), dpack(ld1, 1'b1, 1'b1));
    // Loads are held behind the older store
    expect_quiet(6);
    wake[0] = '{valid: 1'b1, tag: 6'd30};
    tick();
    wake = '0;
    wait_issued(3);
    check_uop("first issued uop", st, issued_q[0]);
    check_uop("second issued uop", ld0, issued_q[1]);
    check_uop("third issued uop", ld1, issued_q[2]);
    expect_quiet(2);
    // Older ready load goes ahead of a younger blocked store
    ld0    = rand_uop(MEM_LOAD);
    st     = rand_uop(MEM_STORE);
    st.rs1 = 6'd31;
    issued_q.delete();
    dispatch(2'b11, dpack(ld0, 1'b1, 1'b1), dpack(st, 1'b0, 1'b1));
    expect_issue(ld0);
    expect_quiet(4);
    wake[1] = '{valid: 1'b1, tag: 6'd31};
    tick();
    wake = '0;
    wait_issued(2);
    check_uop("store after load", st, issued_q[1]);
    expect_quiet(2);
endtask

// All slots taken by blocked uops, then woken two per cycle
task automatic fill_and_drain();
    mem_uop_t exp_q[$];
    mem_uop_t u0;
    mem_uop_t u1;
    issued_q.delete();
    for (int i = 0; i < IQ_DEPTH; i += 2) begin
        u0     = rand_uop(MEM_LOAD);
        u1     = rand_uop(MEM_STORE);
        u0.rs1 = prf_t'(40 + i);
        u1.rs1 = prf_t'(41 + i);
        exp_q.push_back(u0);
        exp_q.push_back(u1);
        if (i < IQ_DEPTH - 2) begin
            dispatch(2'b11, dpack(u0, 1'b0, 1'b1), dpack(u1, 1'b0, 1'b1));
        end else begin
            // Last pair goes one at a time, a single free slot opens lane 0 only
            dispatch(2'b01, dpack(u0, 1'b0, 1'b1), '0);
            check_ready("disp_ready", 2'b01, disp_ready);
            dispatch(2'b01, dpack(u1, 1'b0, 1'b1), '0);
        end
    end
    check_ready("disp_ready", 2'b00, disp_ready);
    for (int i = 0; i < IQ_DEPTH; i += 2) begin
        wake[0] = '{valid: 1'b1, tag: prf_t'(40 + i)};
        wake[1] = '{valid: 1'b1, tag: prf_t'(41 + i)};
        tick();
    end
    wake = '0;
    wait_issued(IQ_DEPTH);
    expect_quiet(3);
    check_each_once(exp_q);
    check_ready("disp_ready", 2'b11, disp_ready);
endtask

task automatic stall_hold();
    mem_uop_t exp_q[$];
    mem_uop_t a;
    mem_uop_t b;
    mem_uop_t c;
    a = rand_uop(MEM_LOAD);
    b = rand_uop(MEM_LOAD);
    c = rand_uop(MEM_LOAD);
    exp_q.push_back(a);
    exp_q.push_back(b);
    exp_q.push_back(c);
    issued_q.delete();
    dispatch(2'b11, dpack(a, 1'b1, 1'b1), dpack(b, 1'b1, 1'b1));
    expect_issue(a);
    issue_stall = 1'b1;
    // Dispatch keeps going while the port is frozen
    dispatch(2'b01, dpack(c, 1'b1, 1'b1), '0);
    repeat (5) begin
        tick();
        check_bit("issue_valid", 1'b1, issue_valid);
        check_uop("issue_uop", a, issue_uop);
    end
    issue_stall = 1'b0;
    wait_issued(3);
    expect_quiet(3);
    check_each_once(exp_q);
endtask

`endif

// File: tb/tb_mem_issue_queue.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_issue_queue
    import mem_iq_pkg::*;
#(
    parameter int IQ_DEPTH = 8
);

    // ========================================================================
    // Clock, reset and run limit
    // ========================================================================

    localparam int CLK_PERIOD = 20;
    // Six tests of at most about 150 cycles each, plus margin
    localparam int MAX_CYCLES = 2000;

    logic                   clk;
    logic                   rst;
    logic [1:0]             disp_valid;
    mem_dispatch_t [1:0]    disp_pack;
    logic [1:0]             disp_ready;
    wake_t [WAKE_PORTS-1:0] wake;
    logic                   issue_stall;
    logic                   issue_valid;
    mem_uop_t               issue_uop;

    int       seed = 33893;
    int       cycle_cnt = 0;
    // Uops taken by the memory pipe, oldest first
    mem_uop_t issued_q[$];

    initial begin
        clk = 1'b0;
    end

    always begin
        #(CLK_PERIOD / 2) clk = ~clk;
    end

    mem_issue_queue #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .disp_valid  (disp_valid),
        .disp_pack   (disp_pack),
        .disp_ready  (disp_ready),
        .wake        (wake),
        .issue_stall (issue_stall),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop)
    );

    // Hard stop in case the DUT never answers
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout: tests still running after %0d cycles", MAX_CYCLES));
        end
    end

    // ========================================================================
    // Failure reporting and compare tasks
    // ========================================================================

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_uop(input string name, input mem_uop_t exp, input mem_uop_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error at time %0t: %s expected %h, got %h",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Error at time %0t: %s expected %b, got %b",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_ready(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Error at time %0t: %s expected %b, got %b",
                                $time, name, exp, act));
        end
    endtask

    // ========================================================================
    // Stimulus helpers
    // ========================================================================

    // One cycle forward, inputs change right after this returns
    task automatic tick();
        @(negedge clk);
        // Register was reloaded at the last edge only when not stalled
        if (issue_valid && !issue_stall) begin
            issued_q.push_back(issue_uop);
        end
    endtask

    // Random registers and ROB tag around a fixed opcode
    function automatic mem_uop_t rand_uop(input mem_op_t op);
        mem_uop_t u;
        u.op      = op;
        u.rd      = prf_t'($random(seed));
        u.rs1     = prf_t'($random(seed));
        u.rs2     = prf_t'($random(seed));
        u.rob_tag = rob_tag_t'($random(seed));
        return u;
    endfunction

    function automatic mem_dispatch_t dpack(input mem_uop_t u, input logic r1, input logic r2);
        mem_dispatch_t d;
        d.uop       = u;
        d.rs1_ready = r1;
        d.rs2_ready = r2;
        return d;
    endfunction

    // Offer one or two lanes for a single edge, any pending wake goes along
    task automatic dispatch(input logic [1:0] lanes, input mem_dispatch_t d0,
                            input mem_dispatch_t d1);
        if ((disp_ready & lanes) != lanes) begin
            abort_run("Dispatch lanes were not ready when the queue should have room");
        end
        disp_valid   = lanes;
        disp_pack[0] = d0;
        disp_pack[1] = d1;
        tick();
        disp_valid = 2'b00;
        wake       = '0;
    endtask

    // Issuable at the last edge, visible at the port after the next one
    task automatic expect_issue(input mem_uop_t u);
        check_bit("issue_valid", 1'b0, issue_valid);
        tick();
        check_bit("issue_valid", 1'b1, issue_valid);
        check_uop("issue_uop", u, issue_uop);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            tick();
            check_bit("issue_valid", 1'b0, issue_valid);
        end
    endtask

    task automatic wait_issued(input int n);
        int waited;
        waited = 0;
        while (issued_q.size() < n && waited < 50) begin
            tick();
            waited++;
        end
        if (issued_q.size() != n) begin
            abort_run($sformatf("Expected %0d issued uops but saw %0d", n, issued_q.size()));
        end
    endtask

    task automatic check_each_once(input mem_uop_t exp_q[$]);
        int hits;
        foreach (exp_q[e]) begin
            hits = 0;
            foreach (issued_q[a]) begin
                if (issued_q[a] == exp_q[e]) begin
                    hits++;
                end
            end
            if (hits != 1) begin
                abort_run($sformatf("Uop %h issued %0d times instead of once", exp_q[e], hits));
            end
        end
    endtask

    `include "tb_mem_iq_tasks.svh"

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        disp_valid  = 2'b00;
        disp_pack   = '0;
        wake        = '0;
        issue_stall = 1'b0;
        rst         = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_reset_state();
        ready_load_issue();
        wakeup_and_bypass();
        load_store_order();
        fill_and_drain();
        stall_hold();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
